//--- thread_control_unit.f
+incdir+include
src/ctrl_pkg.sv
src/interrupt_controller.sv
src/control_registers.sv
src/creg_access_port.sv
src/thread_control_unit.sv
verif/thread_control_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 \
    --top-module thread_control_unit_tb \
    -f thread_control_unit.f \
    -o thread_control_unit_sim

./obj_dir/thread_control_unit_sim 2>&1 | tee sim.log

if grep -q "RESULT: FAIL" sim.log
then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"

//--- verif/thread_control_unit_tb.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module thread_control_unit_tb;

    typedef enum {K_ACCESS, K_TRAP, K_ERET, K_LINES, K_PROBE} kind_t;
    typedef enum {P_PENDING_ANY, P_FLAGS, P_ERET_ADDRESS, P_TRAP_HANDLER} probe_t;

    // One row of stimulus with data used as trap PC or interrupt lines
    typedef struct
    {
        string                 name;
        kind_t                 kind;
        ctrl_pkg::creg_op_t    op;
        int                    thread;
        ctrl_pkg::creg_index_t index;
        ctrl_pkg::trap_cause_t cause;
        ctrl_pkg::scalar_t     data;
        ctrl_pkg::scalar_t     expected;
        probe_t                probe;
        int                    stall;
    } entry_t;

    localparam int RESET_CYCLES = 16;
    localparam int ENTRY_CYCLES = 50;
    localparam int TID_BITS = $bits(ctrl_pkg::thread_idx_t);
    localparam ctrl_pkg::scalar_t IRQ_BITS = (1 << `CTRL_NUM_INTERRUPTS) - 1;

    logic                            clk;
    logic                            reset;
    logic [`CTRL_NUM_INTERRUPTS-1:0] interrupt_req;
    logic                            req_valid;
    logic                            req_ready;
    ctrl_pkg::creg_op_t              req_op;
    ctrl_pkg::thread_idx_t           req_thread;
    ctrl_pkg::creg_index_t           req_index;
    ctrl_pkg::scalar_t               req_data;
    logic                            resp_valid;
    logic                            resp_ready;
    ctrl_pkg::scalar_t               resp_data;
    logic                            trap;
    logic                            eret;
    ctrl_pkg::thread_idx_t           event_thread;
    ctrl_pkg::trap_cause_t           trap_cause;
    ctrl_pkg::scalar_t               trap_pc;
    logic [`CTRL_THREADS-1:0]        supervisor_en;
    logic [`CTRL_THREADS-1:0]        mmu_en;
    logic [`CTRL_THREADS-1:0]        interrupt_en;
    ctrl_pkg::scalar_t               eret_address [`CTRL_THREADS];
    logic [`CTRL_THREADS-1:0]        interrupt_pending_any;
    ctrl_pkg::scalar_t               trap_handler;

    entry_t            entries [$];
    ctrl_pkg::scalar_t scratch [`CTRL_THREADS];
    bit                table_built;

    thread_control_unit UUT
    (
        .clk                   (clk),
        .reset                 (reset),
        .interrupt_req         (interrupt_req),
        .req_valid             (req_valid),
        .req_ready             (req_ready),
        .req_op                (req_op),
        .req_thread            (req_thread),
        .req_index             (req_index),
        .req_data              (req_data),
        .resp_valid            (resp_valid),
        .resp_ready            (resp_ready),
        .resp_data             (resp_data),
        .trap                  (trap),
        .eret                  (eret),
        .event_thread          (event_thread),
        .trap_cause            (trap_cause),
        .trap_pc               (trap_pc),
        .supervisor_en         (supervisor_en),
        .mmu_en                (mmu_en),
        .interrupt_en          (interrupt_en),
        .eret_address          (eret_address),
        .interrupt_pending_any (interrupt_pending_any),
        .trap_handler          (trap_handler)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    function automatic entry_t blank_row(input string name, input kind_t kind);
        entry_t e;
        e.name = name;
        e.kind = kind;
        e.op = ctrl_pkg::OP_READ;
        e.thread = 0;
        e.index = ctrl_pkg::CR_FLAGS;
        e.cause = '0;
        e.data = '0;
        e.expected = '0;
        e.probe = P_PENDING_ANY;
        e.stall = 0;
        return e;
    endfunction

    task automatic read_row(input string name, input int thread,
        input ctrl_pkg::creg_index_t index, input ctrl_pkg::scalar_t expected);
        entry_t e;
        e = blank_row(name, K_ACCESS);
        e.thread = thread;
        e.index = index;
        e.expected = expected;
        e.stall = $urandom % 4;
        entries.push_back(e);
    endtask

    // Every write answers with zero
    task automatic write_row(input string name, input int thread,
        input ctrl_pkg::creg_index_t index, input ctrl_pkg::scalar_t data);
        entry_t e;
        e = blank_row(name, K_ACCESS);
        e.op = ctrl_pkg::OP_WRITE;
        e.thread = thread;
        e.index = index;
        e.data = data;
        e.stall = $urandom % 4;
        entries.push_back(e);
    endtask

    task automatic trap_row(input string name, input int thread,
        input ctrl_pkg::trap_cause_t cause, input ctrl_pkg::scalar_t pc);
        entry_t e;
        e = blank_row(name, K_TRAP);
        e.thread = thread;
        e.cause = cause;
        e.data = pc;
        entries.push_back(e);
    endtask

    task automatic eret_row(input string name, input int thread);
        entry_t e;
        e = blank_row(name, K_ERET);
        e.thread = thread;
        entries.push_back(e);
    endtask

    task automatic lines_row(input string name, input ctrl_pkg::scalar_t lines);
        entry_t e;
        e = blank_row(name, K_LINES);
        e.data = lines;
        entries.push_back(e);
    endtask

    task automatic probe_row(input string name, input probe_t probe, input int thread,
        input ctrl_pkg::scalar_t expected);
        entry_t e;
        e = blank_row(name, K_PROBE);
        e.probe = probe;
        e.thread = thread;
        e.expected = expected;
        entries.push_back(e);
    endtask

    task automatic stall_last(input int cycles);
        entries[entries.size() - 1].stall = cycles;
    endtask

    task automatic build_table();
        ctrl_pkg::scalar_t value;
        ctrl_pkg::scalar_t pc_a;
        ctrl_pkg::scalar_t pc_b;

        // Reset state leaves supervisor as the only flag
        for (int t = 0; t < `CTRL_THREADS; t++)
            read_row($sformatf("reset flags t%0d", t), t, ctrl_pkg::CR_FLAGS, 32'h4);
        probe_row("reset pending_any", P_PENDING_ANY, 0, 32'h0);

        // Register round trip
        for (int t = 0; t < `CTRL_THREADS; t++)
        begin
            scratch[t] = $urandom;
            write_row($sformatf("scratchpad write t%0d", t), t, ctrl_pkg::CR_SCRATCHPAD,
                scratch[t]);
            read_row($sformatf("scratchpad read t%0d", t), t, ctrl_pkg::CR_SCRATCHPAD,
                scratch[t]);
            value = $urandom;
            write_row($sformatf("handler write t%0d", t), t, ctrl_pkg::CR_TRAP_HANDLER, value);
            read_row($sformatf("handler read t%0d", t), t, ctrl_pkg::CR_TRAP_HANDLER, value);
            probe_row($sformatf("handler port t%0d", t), P_TRAP_HANDLER, 0, value);
            value = $urandom;
            write_row($sformatf("enable write t%0d", t), t, ctrl_pkg::CR_INTERRUPT_ENABLE,
                value);
            read_row($sformatf("enable read t%0d", t), t, ctrl_pkg::CR_INTERRUPT_ENABLE,
                value & IRQ_BITS);
            read_row($sformatf("thread id t%0d", t), t, ctrl_pkg::CR_THREAD_ID,
                ctrl_pkg::scalar_t'((`CTRL_CORE_ID << TID_BITS) + t));
            read_row($sformatf("unknown index t%0d", t), t,
                ctrl_pkg::creg_index_t'(4'(12 + t)), '1);
        end
        for (int t = 0; t < `CTRL_THREADS; t++)
            write_row($sformatf("mask clear t%0d", t), t, ctrl_pkg::CR_INTERRUPT_ENABLE, '0);

        // Trap stack on thread 3 starting with mmu and interrupts on
        pc_a = 32'h1000_0040;
        pc_b = 32'h2000_0a84;
        write_row("flags set", 3, ctrl_pkg::CR_FLAGS, 32'h3);
        probe_row("flags before trap", P_FLAGS, 3, 32'h3);
        trap_row("trap interrupt", 3, ctrl_pkg::TT_INTERRUPT, pc_a);
        read_row("trap pc", 3, ctrl_pkg::CR_TRAP_PC, pc_a);
        read_row("trap cause", 3, ctrl_pkg::CR_TRAP_CAUSE, 32'h1);
        read_row("flags after trap", 3, ctrl_pkg::CR_FLAGS, 32'h6);
        read_row("saved flags", 3, ctrl_pkg::CR_SAVED_FLAGS, 32'h3);
        probe_row("eret_address after trap", P_ERET_ADDRESS, 3, pc_a);
        // TLB miss also drops mmu_en
        trap_row("trap tlb miss", 3, ctrl_pkg::TT_TLB_MISS, pc_b);
        probe_row("flags after tlb miss", P_FLAGS, 3, 32'h4);
        read_row("tlb miss cause", 3, ctrl_pkg::CR_TRAP_CAUSE, 32'h2);
        read_row("saved flags nested", 3, ctrl_pkg::CR_SAVED_FLAGS, 32'h6);
        probe_row("eret_address nested", P_ERET_ADDRESS, 3, pc_b);
        eret_row("eret nested", 3);
        probe_row("flags after first eret", P_FLAGS, 3, 32'h6);
        probe_row("eret_address after eret", P_ERET_ADDRESS, 3, pc_a);
        eret_row("eret outer", 3);
        probe_row("flags restored", P_FLAGS, 3, 32'h3);
        probe_row("other thread flags", P_FLAGS, 0, 32'h4);
        read_row("scratchpad after eret", 3, ctrl_pkg::CR_SCRATCHPAD, scratch[3]);

        // Edge interrupt on line 3 for thread 1
        write_row("trigger edge", 1, ctrl_pkg::CR_INTERRUPT_TRIGGER, 32'h0);
        write_row("enable line 3 t1", 1, ctrl_pkg::CR_INTERRUPT_ENABLE, 32'h08);
        lines_row("raise line 3", 32'h08);
        probe_row("edge pending_any", P_PENDING_ANY, 0, 32'h2);
        read_row("edge pending read", 1, ctrl_pkg::CR_INTERRUPT_PENDING, 32'h08);
        write_row("edge ack t1", 1, ctrl_pkg::CR_INTERRUPT_ACK, 32'h08);
        read_row("pending after ack", 1, ctrl_pkg::CR_INTERRUPT_PENDING, 32'h0);
        probe_row("pending_any after ack", P_PENDING_ANY, 0, 32'h0);
        lines_row("drop line 3", 32'h0);

        // Thread 2 still holds the edge of line 3 and an ack on thread 0 leaves it alone
        write_row("enable line 3 t2", 2, ctrl_pkg::CR_INTERRUPT_ENABLE, 32'h08);
        probe_row("latched pending t2", P_PENDING_ANY, 0, 32'h4);
        write_row("ack other thread", 0, ctrl_pkg::CR_INTERRUPT_ACK, 32'h08);
        probe_row("t2 kept after other ack", P_PENDING_ANY, 0, 32'h4);
        read_row("t2 latch kept", 2, ctrl_pkg::CR_INTERRUPT_PENDING, 32'h08);
        write_row("ack t2", 2, ctrl_pkg::CR_INTERRUPT_ACK, 32'h08);
        read_row("t2 latch cleared", 2, ctrl_pkg::CR_INTERRUPT_PENDING, 32'h0);

        // Level trigger on line 5
        write_row("trigger level 5", 2, ctrl_pkg::CR_INTERRUPT_TRIGGER, 32'h20);
        write_row("enable lines 3 5 t2", 2, ctrl_pkg::CR_INTERRUPT_ENABLE, 32'h28);
        lines_row("raise line 5", 32'h20);
        probe_row("level pending_any high", P_PENDING_ANY, 0, 32'h4);
        read_row("level pending read", 2, ctrl_pkg::CR_INTERRUPT_PENDING, 32'h20);
        lines_row("drop line 5", 32'h0);
        probe_row("level pending_any low", P_PENDING_ANY, 0, 32'h0);
        read_row("level pending cleared", 2, ctrl_pkg::CR_INTERRUPT_PENDING, 32'h0);

        // Line 6 is not in any mask
        write_row("trigger level 5 6", 2, ctrl_pkg::CR_INTERRUPT_TRIGGER, 32'h60);
        lines_row("raise masked line 6", 32'h40);
        probe_row("masked pending_any", P_PENDING_ANY, 0, 32'h0);
        read_row("masked pending read", 2, ctrl_pkg::CR_INTERRUPT_PENDING, 32'h0);
        lines_row("drop line 6", 32'h0);

        // Long response stalls
        read_row("stalled read", 0, ctrl_pkg::CR_SCRATCHPAD, scratch[0]);
        stall_last(8 + $urandom % 12);
        value = $urandom;
        write_row("stalled write", 1, ctrl_pkg::CR_SCRATCHPAD, value);
        stall_last(8 + $urandom % 12);
        read_row("read after stalled write", 1, ctrl_pkg::CR_SCRATCHPAD, value);
        stall_last(8 + $urandom % 12);
    endtask

    task automatic check_value(input string name, input ctrl_pkg::scalar_t expected,
        input ctrl_pkg::scalar_t actual);
        assert (actual === expected)
        else
        begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Check failed");
        end
    endtask

    task automatic issue_request(input entry_t e);
        ctrl_pkg::scalar_t held;
        int                cycles;

        @(negedge clk);
        req_valid = 1'b1;
        req_op = e.op;
        req_thread = ctrl_pkg::thread_idx_t'(e.thread);
        req_index = e.index;
        req_data = e.data;
        while (!req_ready)
            @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        cycles = 0;
        while (!resp_valid)
        begin
            @(negedge clk);
            cycles++;
        end
        check_value({e.name, " latency"}, 32'd2, ctrl_pkg::scalar_t'(cycles));
        held = resp_data;
        // Response stays put while the host holds off
        repeat (e.stall)
        begin
            @(negedge clk);
            check_value({e.name, " resp_valid held"}, 32'd1, ctrl_pkg::scalar_t'(resp_valid));
            check_value({e.name, " resp_data held"}, held, resp_data);
            check_value({e.name, " req_ready in flight"}, 32'd0,
                ctrl_pkg::scalar_t'(req_ready));
        end
        resp_ready = 1'b1;
        check_value(e.name, e.expected, resp_data);
        @(negedge clk);
        resp_ready = 1'b0;
        check_value({e.name, " resp_valid after transfer"}, 32'd0,
            ctrl_pkg::scalar_t'(resp_valid));
        check_value({e.name, " req_ready after transfer"}, 32'd1,
            ctrl_pkg::scalar_t'(req_ready));
    endtask

    task automatic pulse_writeback(input entry_t e);
        @(negedge clk);
        event_thread = ctrl_pkg::thread_idx_t'(e.thread);
        trap_cause = e.cause;
        trap_pc = e.data;
        if (e.kind == K_TRAP)
            trap = 1'b1;
        else
            eret = 1'b1;
        @(negedge clk);
        trap = 1'b0;
        eret = 1'b0;
    endtask

    task automatic drive_lines(input entry_t e);
        @(negedge clk);
        interrupt_req = e.data[`CTRL_NUM_INTERRUPTS-1:0];
    endtask

    task automatic sample_probe(input entry_t e);
        ctrl_pkg::scalar_t actual;

        @(negedge clk);
        case (e.probe)
            P_PENDING_ANY:
                actual = ctrl_pkg::scalar_t'(interrupt_pending_any);
            P_FLAGS:
                actual = ctrl_pkg::scalar_t'({supervisor_en[e.thread], mmu_en[e.thread],
                    interrupt_en[e.thread]});
            P_TRAP_HANDLER:
                actual = trap_handler;
            default:
                actual = eret_address[e.thread];
        endcase
        check_value(e.name, e.expected, actual);
    endtask

    // Ends a run that hangs on a handshake
    initial
    begin
        wait (table_built);
        repeat (RESET_CYCLES + ENTRY_CYCLES * entries.size())
            @(posedge clk);
        $display("Run timed out waiting for a handshake");
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        void'($urandom(32'h2d65_c8cb));
        reset = 1'b1;
        interrupt_req = '0;
        req_valid = 1'b0;
        req_op = ctrl_pkg::OP_READ;
        req_thread = '0;
        req_index = ctrl_pkg::CR_FLAGS;
        req_data = '0;
        resp_ready = 1'b0;
        trap = 1'b0;
        eret = 1'b0;
        event_thread = '0;
        trap_cause = '0;
        trap_pc = '0;
        table_built = 1'b0;

        build_table();
        table_built = 1'b1;

        repeat (RESET_CYCLES)
            @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (entries[i])
        begin
            case (entries[i].kind)
                K_ACCESS:
                    issue_request(entries[i]);
                K_TRAP, K_ERET:
                    pulse_writeback(entries[i]);
                K_LINES:
                    drive_lines(entries[i]);
                default:
                    sample_probe(entries[i]);
            endcase
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- src/thread_control_unit.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module thread_control_unit
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic [`CTRL_NUM_INTERRUPTS-1:0] interrupt_req,
    input  logic                            req_valid,
    output logic                            req_ready,
    input  ctrl_pkg::creg_op_t              req_op,
    input  ctrl_pkg::thread_idx_t           req_thread,
    input  ctrl_pkg::creg_index_t           req_index,
    input  ctrl_pkg::scalar_t               req_data,
    output logic                            resp_valid,
    input  logic                            resp_ready,
    output ctrl_pkg::scalar_t               resp_data,
    input  logic                            trap,
    input  logic                            eret,
    input  ctrl_pkg::thread_idx_t           event_thread,
    input  ctrl_pkg::trap_cause_t           trap_cause,
    input  ctrl_pkg::scalar_t               trap_pc,
    output logic [`CTRL_THREADS-1:0]        supervisor_en,
    output logic [`CTRL_THREADS-1:0]        mmu_en,
    output logic [`CTRL_THREADS-1:0]        interrupt_en,
    output ctrl_pkg::scalar_t               eret_address [`CTRL_THREADS],
    output logic [`CTRL_THREADS-1:0]        interrupt_pending_any,
    output ctrl_pkg::scalar_t               trap_handler
);

    logic                            read_en;
    logic                            write_en;
    ctrl_pkg::thread_idx_t           access_thread;
    ctrl_pkg::creg_index_t           access_index;
    ctrl_pkg::scalar_t               access_data;
    ctrl_pkg::scalar_t               read_val;
    logic [`CTRL_NUM_INTERRUPTS-1:0] pending [`CTRL_THREADS];
    logic [`CTRL_NUM_INTERRUPTS-1:0] interrupt_mask [`CTRL_THREADS];
    logic [`CTRL_NUM_INTERRUPTS-1:0] trigger_type;
    logic                            ack_en;
    ctrl_pkg::thread_idx_t           ack_thread;
    logic [`CTRL_NUM_INTERRUPTS-1:0] ack_value;

    creg_access_port port_inst
    (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_op        (req_op),
        .req_thread    (req_thread),
        .req_index     (req_index),
        .req_data      (req_data),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp_data     (resp_data),
        .read_en       (read_en),
        .write_en      (write_en),
        .access_thread (access_thread),
        .access_index  (access_index),
        .access_data   (access_data),
        .read_val      (read_val)
    );

    control_registers regs_inst
    (
        .clk            (clk),
        .reset          (reset),
        .read_en        (read_en),
        .write_en       (write_en),
        .access_thread  (access_thread),
        .access_index   (access_index),
        .access_data    (access_data),
        .read_val       (read_val),
        .trap           (trap),
        .eret           (eret),
        .event_thread   (event_thread),
        .trap_cause     (trap_cause),
        .trap_pc        (trap_pc),
        .pending        (pending),
        .interrupt_mask (interrupt_mask),
        .trigger_type   (trigger_type),
        .ack_en         (ack_en),
        .ack_thread     (ack_thread),
        .ack_value      (ack_value),
        .supervisor_en  (supervisor_en),
        .mmu_en         (mmu_en),
        .interrupt_en   (interrupt_en),
        .eret_address   (eret_address),
        .trap_handler   (trap_handler)
    );

    interrupt_controller irq_inst
    (
        .clk                   (clk),
        .reset                 (reset),
        .interrupt_req         (interrupt_req),
        .interrupt_mask        (interrupt_mask),
        .trigger_type          (trigger_type),
        .ack_en                (ack_en),
        .ack_thread            (ack_thread),
        .ack_value             (ack_value),
        .pending               (pending),
        .interrupt_pending_any (interrupt_pending_any)
    );

endmodule

//--- src/creg_access_port.sv
`timescale 1ns/1ps

module creg_access_port
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  ctrl_pkg::creg_op_t    req_op,
    input  ctrl_pkg::thread_idx_t req_thread,
    input  ctrl_pkg::creg_index_t req_index,
    input  ctrl_pkg::scalar_t     req_data,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output ctrl_pkg::scalar_t     resp_data,
    output logic                  read_en,
    output logic                  write_en,
    output ctrl_pkg::thread_idx_t access_thread,
    output ctrl_pkg::creg_index_t access_index,
    output ctrl_pkg::scalar_t     access_data,
    input  ctrl_pkg::scalar_t     read_val
);

    typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_RESPOND} state_t;

    state_t             state;
    logic               strobe;
    ctrl_pkg::creg_op_t access_op;

    assign req_ready = state == ST_IDLE;
    assign resp_valid = state == ST_RESPOND;
    assign read_en = strobe && access_op == ctrl_pkg::OP_READ;
    assign write_en = strobe && access_op == ctrl_pkg::OP_WRITE;

    // ACCESS spans the strobe cycle and the wait for the registered read
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            strobe <= 1'b0;
        end
        else
        begin
            strobe <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (req_valid)
                    begin
                        state <= ST_ACCESS;
                        strobe <= 1'b1;
                    end
                end
                ST_ACCESS:
                begin
                    if (!strobe)
                        state <= ST_RESPOND;
                end
                ST_RESPOND:
                begin
                    if (resp_ready)
                        state <= ST_IDLE;
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_valid && req_ready)
        begin
            access_op <= req_op;
            access_thread <= req_thread;
            access_index <= req_index;
            access_data <= req_data;
        end

        // Writes answer with zero
        if (state == ST_ACCESS && !strobe)
            resp_data <= (access_op == ctrl_pkg::OP_WRITE) ? '0 : read_val;
    end

    // Response stays put while the host stalls
    resp_held: assert property (@(posedge clk) disable iff (reset)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data));

endmodule

//--- src/control_registers.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module control_registers
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            read_en,
    input  logic                            write_en,
    input  ctrl_pkg::thread_idx_t           access_thread,
    input  ctrl_pkg::creg_index_t           access_index,
    input  ctrl_pkg::scalar_t               access_data,
    output ctrl_pkg::scalar_t               read_val,
    input  logic                            trap,
    input  logic                            eret,
    input  ctrl_pkg::thread_idx_t           event_thread,
    input  ctrl_pkg::trap_cause_t           trap_cause,
    input  ctrl_pkg::scalar_t               trap_pc,
    input  logic [`CTRL_NUM_INTERRUPTS-1:0] pending [`CTRL_THREADS],
    output logic [`CTRL_NUM_INTERRUPTS-1:0] interrupt_mask [`CTRL_THREADS],
    output logic [`CTRL_NUM_INTERRUPTS-1:0] trigger_type,
    output logic                            ack_en,
    output ctrl_pkg::thread_idx_t           ack_thread,
    output logic [`CTRL_NUM_INTERRUPTS-1:0] ack_value,
    output logic [`CTRL_THREADS-1:0]        supervisor_en,
    output logic [`CTRL_THREADS-1:0]        mmu_en,
    output logic [`CTRL_THREADS-1:0]        interrupt_en,
    output ctrl_pkg::scalar_t               eret_address [`CTRL_THREADS],
    output ctrl_pkg::scalar_t               trap_handler
);

    localparam int FLAG_BITS = $bits(ctrl_pkg::flags_t);
    localparam int TID_BITS = $bits(ctrl_pkg::thread_idx_t);
    localparam logic [`CTRL_DATA_WIDTH-TID_BITS-1:0] CORE_ID = `CTRL_CORE_ID;

    // One level of saved state, level 0 is the live one
    typedef struct packed
    {
        ctrl_pkg::flags_t      flags;
        ctrl_pkg::trap_cause_t cause;
        ctrl_pkg::scalar_t     pc;
        ctrl_pkg::scalar_t     scratchpad;
    } trap_level_t;

    trap_level_t       trap_stack [`CTRL_THREADS][`CTRL_TRAP_LEVELS];
    ctrl_pkg::scalar_t cycle_count;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int t = 0; t < `CTRL_THREADS; t++)
            begin
                for (int l = 0; l < `CTRL_TRAP_LEVELS; l++)
                    trap_stack[t][l] <= '0;
                trap_stack[t][0].flags.supervisor_en <= 1'b1;
                interrupt_mask[t] <= '0;
            end
            trigger_type <= '0;
            trap_handler <= '0;
            cycle_count <= '0;
        end
        else
        begin
            cycle_count <= cycle_count + 1'b1;

            if (trap)
            begin
                // Push current state down one level
                for (int l = 0; l < `CTRL_TRAP_LEVELS - 1; l++)
                    trap_stack[event_thread][l + 1] <= trap_stack[event_thread][l];
                trap_stack[event_thread][0].cause <= trap_cause;
                trap_stack[event_thread][0].pc <= trap_pc;
                trap_stack[event_thread][0].flags.interrupt_en <= 1'b0;
                trap_stack[event_thread][0].flags.supervisor_en <= 1'b1;
                if (trap_cause == ctrl_pkg::TT_TLB_MISS)
                    trap_stack[event_thread][0].flags.mmu_en <= 1'b0;
            end
            else if (eret)
            begin
                // Pop, deepest level stays as it was
                for (int l = 0; l < `CTRL_TRAP_LEVELS - 1; l++)
                    trap_stack[event_thread][l] <= trap_stack[event_thread][l + 1];
            end

            // Later assignment so a write overrides the trap for its field
            if (write_en)
            begin
                case (access_index)
                    ctrl_pkg::CR_FLAGS:
                        trap_stack[access_thread][0].flags <= access_data[FLAG_BITS-1:0];
                    ctrl_pkg::CR_SAVED_FLAGS:
                        trap_stack[access_thread][1].flags <= access_data[FLAG_BITS-1:0];
                    ctrl_pkg::CR_TRAP_PC:
                        trap_stack[access_thread][0].pc <= access_data;
                    ctrl_pkg::CR_TRAP_HANDLER:
                        trap_handler <= access_data;
                    ctrl_pkg::CR_SCRATCHPAD:
                        trap_stack[access_thread][0].scratchpad <= access_data;
                    ctrl_pkg::CR_INTERRUPT_ENABLE:
                        interrupt_mask[access_thread] <= access_data[`CTRL_NUM_INTERRUPTS-1:0];
                    ctrl_pkg::CR_INTERRUPT_TRIGGER:
                        trigger_type <= access_data[`CTRL_NUM_INTERRUPTS-1:0];
                    default:
                        ;
                endcase
            end
        end
    end

    // Acknowledge goes straight to the interrupt latches
    assign ack_en = write_en && access_index == ctrl_pkg::CR_INTERRUPT_ACK;
    assign ack_thread = access_thread;
    assign ack_value = access_data[`CTRL_NUM_INTERRUPTS-1:0];

    for (genvar t = 0; t < `CTRL_THREADS; t++)
    begin : g_thread
        assign supervisor_en[t] = trap_stack[t][0].flags.supervisor_en;
        assign mmu_en[t] = trap_stack[t][0].flags.mmu_en;
        assign interrupt_en[t] = trap_stack[t][0].flags.interrupt_en;
        assign eret_address[t] = trap_stack[t][0].pc;
    end

    always_ff @(posedge clk)
    begin
        if (read_en)
        begin
            case (access_index)
                ctrl_pkg::CR_FLAGS:
                    read_val <= ctrl_pkg::scalar_t'(trap_stack[access_thread][0].flags);
                ctrl_pkg::CR_SAVED_FLAGS:
                    read_val <= ctrl_pkg::scalar_t'(trap_stack[access_thread][1].flags);
                ctrl_pkg::CR_THREAD_ID:
                    read_val <= {CORE_ID, access_thread};
                ctrl_pkg::CR_TRAP_PC:
                    read_val <= trap_stack[access_thread][0].pc;
                ctrl_pkg::CR_TRAP_CAUSE:
                    read_val <= ctrl_pkg::scalar_t'(trap_stack[access_thread][0].cause);
                ctrl_pkg::CR_TRAP_HANDLER:
                    read_val <= trap_handler;
                ctrl_pkg::CR_SCRATCHPAD:
                    read_val <= trap_stack[access_thread][0].scratchpad;
                ctrl_pkg::CR_CYCLE_COUNT:
                    read_val <= cycle_count;
                ctrl_pkg::CR_INTERRUPT_ENABLE:
                    read_val <= ctrl_pkg::scalar_t'(interrupt_mask[access_thread]);
                ctrl_pkg::CR_INTERRUPT_TRIGGER:
                    read_val <= ctrl_pkg::scalar_t'(trigger_type);
                ctrl_pkg::CR_INTERRUPT_PENDING:
                    read_val <= ctrl_pkg::scalar_t'(pending[access_thread]);
                default:
                    read_val <= '1;
            endcase
        end
    end

    // Both come from the writeback stage of one instruction
    trap_eret_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(trap && eret));

    access_strobe_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(read_en && write_en));

endmodule

//--- src/interrupt_controller.sv
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module interrupt_controller
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic [`CTRL_NUM_INTERRUPTS-1:0] interrupt_req,
    input  logic [`CTRL_NUM_INTERRUPTS-1:0] interrupt_mask [`CTRL_THREADS],
    input  logic [`CTRL_NUM_INTERRUPTS-1:0] trigger_type,
    input  logic                            ack_en,
    input  ctrl_pkg::thread_idx_t           ack_thread,
    input  logic [`CTRL_NUM_INTERRUPTS-1:0] ack_value,
    output logic [`CTRL_NUM_INTERRUPTS-1:0] pending [`CTRL_THREADS],
    output logic [`CTRL_THREADS-1:0]        interrupt_pending_any
);

    logic [`CTRL_NUM_INTERRUPTS-1:0] req_prev;
    logic [`CTRL_NUM_INTERRUPTS-1:0] req_edge;
    logic [`CTRL_NUM_INTERRUPTS-1:0] edge_latch [`CTRL_THREADS];

    // Previous sample of the request lines for rising edge detection
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            req_prev <= '0;
        else
            req_prev <= interrupt_req;
    end

    assign req_edge = interrupt_req & ~req_prev;

    for (genvar t = 0; t < `CTRL_THREADS; t++)
    begin : g_thread
        logic [`CTRL_NUM_INTERRUPTS-1:0] ack_mask;
        logic [`CTRL_NUM_INTERRUPTS-1:0] raw_pending;

        // Acknowledge only reaches the thread it names
        assign ack_mask = (ack_en && ack_thread == ctrl_pkg::thread_idx_t'(t))
            ? ack_value : '0;

        // A new edge in the ack cycle wins over the clear
        always_ff @(posedge clk or posedge reset)
        begin
            if (reset)
                edge_latch[t] <= '0;
            else
                edge_latch[t] <= (edge_latch[t] & ~ack_mask) | req_edge;
        end

        // Trigger bit 1 is level, 0 is latched edge
        assign raw_pending = (trigger_type & interrupt_req)
            | (~trigger_type & edge_latch[t]);

        assign pending[t] = raw_pending & interrupt_mask[t];
        assign interrupt_pending_any[t] = |pending[t];
    end

endmodule

//--- src/ctrl_pkg.sv
`include "ctrl_defs.svh"

package ctrl_pkg;

    typedef logic [`CTRL_DATA_WIDTH-1:0] scalar_t;

    typedef logic [$clog2(`CTRL_THREADS)-1:0] thread_idx_t;

    typedef enum logic [3:0]
    {
        CR_FLAGS             = 4'd0,
        CR_SAVED_FLAGS       = 4'd1,
        CR_THREAD_ID         = 4'd2,
        CR_TRAP_PC           = 4'd3,
        CR_TRAP_CAUSE        = 4'd4,
        CR_TRAP_HANDLER      = 4'd5,
        CR_SCRATCHPAD        = 4'd6,
        CR_CYCLE_COUNT       = 4'd7,
        CR_INTERRUPT_ENABLE  = 4'd8,
        CR_INTERRUPT_TRIGGER = 4'd9,
        CR_INTERRUPT_PENDING = 4'd10,
        CR_INTERRUPT_ACK     = 4'd11
    } creg_index_t;

    // Bit 2 down to bit 0
    typedef struct packed
    {
        logic supervisor_en;
        logic mmu_en;
        logic interrupt_en;
    } flags_t;

    typedef logic [3:0] trap_cause_t;

    localparam trap_cause_t TT_INTERRUPT = 4'd1;
    localparam trap_cause_t TT_TLB_MISS  = 4'd2;

    typedef enum logic {OP_READ, OP_WRITE} creg_op_t;

endpackage

//--- include/ctrl_defs.svh
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// Hardware threads in the core
`define CTRL_THREADS 4

// External interrupt request lines
`define CTRL_NUM_INTERRUPTS 8

// Trap stack depth, the current level counts as one
`define CTRL_TRAP_LEVELS 3

// Width of one control register
`define CTRL_DATA_WIDTH 32

// Core number shown in the upper bits of the thread id register
`define CTRL_CORE_ID 0

`endif
